// File: rtl/kbdPkg.sv
package kbdPkg;

	localparam int SCAN_W = 8;

	localparam logic [SCAN_W-1:0] BREAK_CODE = 8'hF0; // Release prefix
	localparam logic [SCAN_W-1:0] EXT_CODE   = 8'hE0; // Extended key prefix
	localparam logic [SCAN_W-1:0] BKSP_CODE  = 8'h66;
	localparam logic [SCAN_W-1:0] ESC_CODE   = 8'h76;

	typedef struct packed {
		logic       valid; // Code is a hex key
		logic [3:0] nibble;
	} nibbleResult_t;

	// Set-2 make codes of the main-row digits and the letters A to F
	function automatic nibbleResult_t scanToNibble(input logic [SCAN_W-1:0] code);
		nibbleResult_t res;
		res.valid  = 1'b1;
		res.nibble = 4'h0;
		case (code)
			8'h45: res.nibble = 4'h0;
			8'h16: res.nibble = 4'h1;
			8'h1E: res.nibble = 4'h2;
			8'h26: res.nibble = 4'h3;
			8'h25: res.nibble = 4'h4;
			8'h2E: res.nibble = 4'h5;
			8'h36: res.nibble = 4'h6;
			8'h3D: res.nibble = 4'h7;
			8'h3E: res.nibble = 4'h8;
			8'h46: res.nibble = 4'h9;
			8'h1C: res.nibble = 4'hA;
			8'h32: res.nibble = 4'hB;
			8'h21: res.nibble = 4'hC;
			8'h23: res.nibble = 4'hD;
			8'h24: res.nibble = 4'hE;
			8'h2B: res.nibble = 4'hF;
			default: res.valid = 1'b0; // Not a hex key
		endcase
		return res;
	endfunction

endpackage

// File: rtl/dispPkg.sv
package dispPkg;

	localparam int VALUE_W = 16; // Value shown on the display
	localparam int DIGITS = 4;
	localparam int SEG_W = 7; // Segments gfedcba

	// One hex digit per display position
	localparam int NIBBLE_W = VALUE_W / DIGITS;

endpackage

// File: rtl/hexTo7Seg.sv
`timescale 1ns/1ps

module hexTo7Seg (
	input  logic [dispPkg::NIBBLE_W-1:0] x,
	output logic [dispPkg::SEG_W-1:0]    z
);

	// Active-low patterns, bit 6 is segment g
	always_comb
	begin
		case (x)
			4'h0: z = 7'h40;
			4'h1: z = 7'h79;
			4'h2: z = 7'h24;
			4'h3: z = 7'h30;
			4'h4: z = 7'h19;
			4'h5: z = 7'h12;
			4'h6: z = 7'h02;
			4'h7: z = 7'h78;
			4'h8: z = 7'h00; // All segments lit
			4'h9: z = 7'h18;
			4'hA: z = 7'h08;
			4'hB: z = 7'h03; // Lower-case b
			4'hC: z = 7'h27; // Lower-case c
			4'hD: z = 7'h21; // Lower-case d
			4'hE: z = 7'h06;
			4'hF: z = 7'h0E;
			default: z = 7'h7F; // Blank
		endcase
	end

endmodule

// File: rtl/ps2Receiver.sv
`timescale 1ns/1ps

module ps2Receiver #(
	parameter int FRAME_TIMEOUT = 2000
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      keyClk,
	input  logic                      keyData,
	output logic                      codeValid,
	output logic [kbdPkg::SCAN_W-1:0] scanCode
);
	import kbdPkg::*;

	localparam int TO_W = $clog2(FRAME_TIMEOUT + 1);

	logic [1:0]        keyClkSync; // Two-flop synchronizer
	logic [1:0]        keyDataSync;
	logic              keyClkPrev;
	logic              keyFall;
	logic              bitIn;
	logic [3:0]        bitCnt; // 0 idle, 1..8 data, 9 parity, 10 stop
	logic [SCAN_W-1:0] shiftReg;
	logic              parityBit;
	logic [TO_W-1:0]   idleCnt;

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			keyClkSync  <= 2'b11; // Bus idles high
			keyDataSync <= 2'b11;
			keyClkPrev  <= 1'b1;
		end
		else
		begin
			keyClkSync  <= {keyClkSync[0], keyClk};
			keyDataSync <= {keyDataSync[0], keyData};
			keyClkPrev  <= keyClkSync[1];
		end
	end

	assign keyFall = keyClkPrev & ~keyClkSync[1];
	assign bitIn = keyDataSync[1];

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			bitCnt    <= 4'd0;
			idleCnt   <= '0;
			codeValid <= 1'b0;
		end
		else
		begin
			codeValid <= 1'b0;
			if (keyFall)
			begin
				idleCnt <= '0;
				if (bitCnt == 4'd0)
				begin
					if (!bitIn)
						bitCnt <= 4'd1; // Start bit seen
				end
				else if (bitCnt == 4'd10)
				begin
					// Stop bit plus odd parity over data and parity bit
					if (bitIn && (^{shiftReg, parityBit}))
						codeValid <= 1'b1;
					bitCnt <= 4'd0;
				end
				else
					bitCnt <= bitCnt + 4'd1;
			end
			else if (bitCnt != 4'd0)
			begin
				if (idleCnt == TO_W'(FRAME_TIMEOUT - 1))
				begin
					bitCnt  <= 4'd0; // Abort partial frame
					idleCnt <= '0;
				end
				else
					idleCnt <= idleCnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (keyFall)
		begin
			if (bitCnt >= 4'd1 && bitCnt <= 4'd8)
				shiftReg <= {bitIn, shiftReg[SCAN_W-1:1]}; // LSB first
			if (bitCnt == 4'd9)
				parityBit <= bitIn;
		end
	end

	always_ff @(posedge clk)
	begin
		if (keyFall && bitCnt == 4'd10)
			scanCode <= shiftReg;
	end

endmodule

// File: rtl/scanFifo.sv
`timescale 1ns/1ps

module scanFifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      push,
	input  logic [kbdPkg::SCAN_W-1:0] pushData,
	input  logic                      pop,
	output logic [kbdPkg::SCAN_W-1:0] popData,
	output logic                      empty,
	output logic                      full,
	output logic                      overflow
);
	import kbdPkg::*;

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	logic [SCAN_W-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0]  wrPtr;
	logic [PTR_W-1:0]  rdPtr;
	logic [PTR_W:0]    count;
	logic              doPush;
	logic              doPop;

	assign empty = (count == '0);
	assign full = (count == (PTR_W + 1)'(FIFO_DEPTH));
	assign doPush = push & ~full; // Code dropped when full
	assign doPop = pop & ~empty;
	assign popData = mem[rdPtr]; // Head entry falls through

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			wrPtr    <= '0;
			rdPtr    <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1; // Wraps at power-of-two depth
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			if (push && full)
				overflow <= 1'b1; // Sticky until reset
		end
	end

endmodule

// File: rtl/hexEntry.sv
`timescale 1ns/1ps

module hexEntry (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        empty,
	input  logic [kbdPkg::SCAN_W-1:0]   popData,
	output logic                        pop,
	output logic [dispPkg::VALUE_W-1:0] value
);
	import kbdPkg::*;
	import dispPkg::*;

	logic          breakPending; // Next code is a release
	logic          extPending; // Next code follows E0
	nibbleResult_t key;

	assign pop = ~empty; // Drain one code per cycle
	assign key = scanToNibble(popData);

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			breakPending <= 1'b0;
			extPending   <= 1'b0;
			value        <= '0;
		end
		else if (pop)
		begin
			if (breakPending)
				breakPending <= 1'b0; // Released key has no effect
			else if (popData == BREAK_CODE)
			begin
				breakPending <= 1'b1;
				extPending   <= 1'b0; // E0 F0 xx release sequence
			end
			else if (extPending)
				extPending <= 1'b0;
			else if (popData == EXT_CODE)
				extPending <= 1'b1;
			else if (key.valid)
				value <= {value[VALUE_W-NIBBLE_W-1:0], key.nibble};
			else if (popData == BKSP_CODE)
				value <= {{NIBBLE_W{1'b0}}, value[VALUE_W-1:NIBBLE_W]};
			else if (popData == ESC_CODE)
				value <= '0;
		end
	end

endmodule

// File: rtl/keyDisplayTop.sv
`timescale 1ns/1ps

module keyDisplayTop #(
	parameter int FIFO_DEPTH = 8,
	parameter int FRAME_TIMEOUT = 2000
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      keyClk,
	input  logic                      keyData,
	output logic [dispPkg::SEG_W-1:0] digit3,
	output logic [dispPkg::SEG_W-1:0] digit2,
	output logic [dispPkg::SEG_W-1:0] digit1,
	output logic [dispPkg::SEG_W-1:0] digit0,
	output logic                      overflow
);
	import kbdPkg::*;
	import dispPkg::*;

	logic               codeValid;
	logic [SCAN_W-1:0]  scanCode;
	logic [SCAN_W-1:0]  popData;
	logic               empty;
	logic               pop;
	logic [VALUE_W-1:0] value;
	logic [SEG_W-1:0]   segs [DIGITS];

	ps2Receiver #(
		.FRAME_TIMEOUT(FRAME_TIMEOUT)
	) i_ps2Receiver (
		.clk(clk),
		.rst(rst),
		.keyClk(keyClk),
		.keyData(keyData),
		.codeValid(codeValid),
		.scanCode(scanCode)
	);

	scanFifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) i_scanFifo (
		.clk(clk),
		.rst(rst),
		.push(codeValid),
		.pushData(scanCode),
		.pop(pop),
		.popData(popData),
		.empty(empty),
		.full(), // Only used inside the FIFO
		.overflow(overflow)
	);

	hexEntry i_hexEntry (
		.clk(clk),
		.rst(rst),
		.empty(empty),
		.popData(popData),
		.pop(pop),
		.value(value)
	);

	// One decoder per digit, digit 0 is the low nibble
	for (genvar i = 0; i < DIGITS; i++)
	begin : g_digit
		hexTo7Seg i_hexTo7Seg (
			.x(value[i*NIBBLE_W +: NIBBLE_W]),
			.z(segs[i])
		);
	end

	assign digit3 = segs[3]; // Top nibble
	assign digit2 = segs[2];
	assign digit1 = segs[1];
	assign digit0 = segs[0];

endmodule

// File: verif/keyDisplay_sva.sv
`timescale 1ns/1ps

module keyDisplaySva (
	input logic clk,
	input logic rst,
	input logic push,
	input logic pop,
	input logic empty,
	input logic full,
	input logic overflow
);

	// Consumer only pops a FIFO that holds data
	popNotEmpty: assert property (@(posedge clk) disable iff (!rst) !(pop && empty))
		else $error("pop seen while FIFO is empty");

	// A dropped code must raise the sticky flag
	overflowOnFull: assert property (@(posedge clk) disable iff (!rst) (push && full) |=> overflow)
		else $error("push into full FIFO did not set overflow");

	fullEmptyExclusive: assert property (@(posedge clk) disable iff (!rst) !(full && empty))
		else $error("FIFO reports full and empty together");

	// Receiver strobe lasts one cycle
	pushIsPulse: assert property (@(posedge clk) disable iff (!rst) push |=> !push)
		else $error("receiver strobe held longer than one cycle");

endmodule

bind scanFifo keyDisplaySva i_keyDisplaySva (
	.clk(clk),
	.rst(rst),
	.push(push),
	.pop(pop),
	.empty(empty),
	.full(full),
	.overflow(overflow)
);

// File: verif/keyDisplayTb.sv
`timescale 1ns/1ps

module keyDisplayTb;
	import kbdPkg::*;
	import dispPkg::*;

	// Active-low gfedcba patterns for hex 0 to F
	localparam logic [6:0] SEG_TABLE [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h18, 7'h08, 7'h03, 7'h27, 7'h21, 7'h06, 7'h0E
	};
	// Set-2 make codes of the keys 0 to F
	localparam logic [7:0] HEX_KEYS [16] = '{
		8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D,
		8'h3E, 8'h46, 8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B
	};

	logic               clk;
	logic               rst;
	logic               keyClk;
	logic               keyData;
	logic [SEG_W-1:0]   digit3;
	logic [SEG_W-1:0]   digit2;
	logic [SEG_W-1:0]   digit1;
	logic [SEG_W-1:0]   digit0;
	logic               overflow;
	logic [VALUE_W-1:0] model; // Expected display value
	integer             seed;

	keyDisplayTop #(
		.FIFO_DEPTH(8),
		.FRAME_TIMEOUT(200) // Short timeout keeps the truncated frame test quick
	) i_keyDisplayTop (
		.clk(clk),
		.rst(rst),
		.keyClk(keyClk),
		.keyData(keyData),
		.digit3(digit3),
		.digit2(digit2),
		.digit1(digit1),
		.digit0(digit0),
		.overflow(overflow)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic stopWithFailure();
		$display("Some tests failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic checkEq(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		if (actual !== expected)
		begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
			stopWithFailure();
		end
	endtask

	task automatic waitCycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// Start, 8 data bits LSB first, odd parity, stop
	task automatic sendFrame(input logic [7:0] code, input bit badParity, input int bitCount);
		logic [10:0] frame;
		int          i;
		frame = {1'b1, (~^code) ^ badParity, code, 1'b0};
		for (i = 0; i < bitCount; i++)
		begin
			keyData = frame[i];
			waitCycles(6);
			keyClk = 1'b0; // Receiver samples here
			waitCycles(6);
			keyClk = 1'b1;
		end
		keyData = 1'b1;
		waitCycles(6);
	endtask

	task automatic sendKey(input logic [7:0] code);
		sendFrame(code, 1'b0, 11);
		sendFrame(BREAK_CODE, 1'b0, 11);
		sendFrame(code, 1'b0, 11);
	endtask

	// Nibble of a hex key is its position in HEX_KEYS
	task automatic updateModel(input logic [7:0] code);
		int j;
		int hit;
		hit = -1;
		for (j = 0; j < 16; j++)
			if (HEX_KEYS[j] == code)
				hit = j;
		if (hit >= 0)
			model = {model[11:0], 4'(hit)};
		else if (code == BKSP_CODE)
			model = {4'h0, model[15:4]};
		else if (code == ESC_CODE)
			model = '0;
	endtask

	// Wait until no code is queued or being strobed
	task automatic waitIdle();
		int n;
		n = 0;
		while (!(i_keyDisplayTop.empty && !i_keyDisplayTop.codeValid))
		begin
			if (n == 20)
			begin
				$display("ERROR: timed out waiting for the scan code pipeline to drain");
				stopWithFailure();
			end
			@(negedge clk);
			n++;
		end
	endtask

	task automatic checkDisplay();
		waitIdle();
		checkEq("digit3", 16'(digit3), 16'(SEG_TABLE[model[15:12]]));
		checkEq("digit2", 16'(digit2), 16'(SEG_TABLE[model[11:8]]));
		checkEq("digit1", 16'(digit1), 16'(SEG_TABLE[model[7:4]]));
		checkEq("digit0", 16'(digit0), 16'(SEG_TABLE[model[3:0]]));
		checkEq("overflow", 16'(overflow), 16'h0);
	endtask

	task automatic testReset();
		model = '0;
		checkDisplay(); // All zeros after reset
	endtask

	task automatic testRandomKeys();
		int k;
		int idx;
		for (k = 0; k < 12; k++)
		begin
			idx = $random(seed) & 15;
			sendKey(HEX_KEYS[idx]);
			updateModel(HEX_KEYS[idx]);
			checkDisplay();
		end
	endtask

	task automatic testEditKeys();
		sendKey(BKSP_CODE);
		updateModel(BKSP_CODE);
		checkDisplay();
		sendKey(ESC_CODE);
		updateModel(ESC_CODE);
		checkDisplay();
	endtask

	task automatic testBadParity();
		sendFrame(HEX_KEYS[5], 1'b1, 11);
		checkDisplay(); // Frame dropped
		sendKey(HEX_KEYS[7]);
		updateModel(HEX_KEYS[7]);
		checkDisplay();
	endtask

	task automatic testTruncatedFrame();
		sendFrame(HEX_KEYS[9], 1'b0, 5);
		waitCycles(250); // Longer than FRAME_TIMEOUT
		checkDisplay();
		sendKey(HEX_KEYS[12]);
		updateModel(HEX_KEYS[12]);
		checkDisplay();
	endtask

	task automatic testExtendedKey();
		sendFrame(EXT_CODE, 1'b0, 11);
		sendFrame(HEX_KEYS[3], 1'b0, 11);
		checkDisplay();
		sendFrame(EXT_CODE, 1'b0, 11); // Extended release E0 F0 xx
		sendFrame(BREAK_CODE, 1'b0, 11);
		sendFrame(HEX_KEYS[3], 1'b0, 11);
		checkDisplay();
	endtask

	initial
	begin
		seed = 5;
		model = '0;
		rst = 1'b0;
		keyClk = 1'b1; // PS/2 bus idles high
		keyData = 1'b1;
		repeat (3) @(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		testReset();
		testRandomKeys();
		testEditKeys();
		testBadParity();
		testTruncatedFrame();
		testExtendedKey();
		$display("All tests passed");
		$finish;
	end

endmodule

// File: filelist.f
rtl/kbdPkg.sv
rtl/dispPkg.sv
rtl/hexTo7Seg.sv
rtl/ps2Receiver.sv
rtl/scanFifo.sv
rtl/hexEntry.sv
rtl/keyDisplayTop.sv
verif/keyDisplay_sva.sv
verif/keyDisplayTb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module keyDisplayTb -f filelist.f \
	-o keyDisplaySim \
	&& ./obj_dir/keyDisplaySim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log \
	&& echo "Simulation PASSED" \
	|| { echo "Simulation FAILED"; exit 1; }
